//--- src/rename_pkg.sv
package rename_pkg;

	// ************************************************************************
	// architectural and physical register space
	// ************************************************************************

	localparam int AR_BITS = 5;	// arch register index
	localparam int NUM_AR = 32;
	localparam int PR_BITS = 7;	// physical tag
	localparam int NUM_PR = 128;

	// tags not mapped at reset sit in the free list
	localparam int NUM_FREE = NUM_PR - NUM_AR;
	localparam int FL_PTR_BITS = 7;	// indexes NUM_FREE+1 slots

	localparam int CDB_WIDTH = 2;	// completion lanes

	localparam int RQ_DEPTH = 16;
	localparam int RQ_PTR_BITS = 4;

	// ************************************************************************
	// operand selects from decode
	// ************************************************************************

	typedef enum logic [1:0] {
		opa_is_rega,	// only this one reads a register
		opa_is_npc,
		opa_is_pc,
		opa_is_zero
	} opa_select_t;

	typedef enum logic [1:0] {
		opb_is_regb,	// only this one reads a register
		opb_is_imm,
		opb_is_br_disp,
		opb_is_zero
	} opb_select_t;

endpackage

//--- src/map_table.sv
`timescale 1ns/1ps

module map_table import rename_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic recover,
	input  logic alloc0,
	input  logic alloc1,
	input  opa_select_t opa_select0,
	input  opa_select_t opa_select1,
	input  opb_select_t opb_select0,
	input  opb_select_t opb_select1,
	input  logic [AR_BITS-1:0] ra_idx0,
	input  logic [AR_BITS-1:0] ra_idx1,
	input  logic [AR_BITS-1:0] rb_idx0,
	input  logic [AR_BITS-1:0] rb_idx1,
	input  logic [AR_BITS-1:0] dest_idx0,
	input  logic [AR_BITS-1:0] dest_idx1,
	input  logic [PR_BITS-1:0] fl_pr0,
	input  logic [PR_BITS-1:0] fl_pr1,
	input  logic [CDB_WIDTH-1:0] cdb_valid,
	input  logic [CDB_WIDTH-1:0][AR_BITS-1:0] cdb_ar,
	input  logic [CDB_WIDTH-1:0][PR_BITS-1:0] cdb_pr,
	input  logic ret_valid0,
	input  logic ret_valid1,
	input  logic [AR_BITS-1:0] ret_ar0,
	input  logic [AR_BITS-1:0] ret_ar1,
	input  logic [PR_BITS-1:0] ret_pr0,
	input  logic [PR_BITS-1:0] ret_pr1,
	output logic [PR_BITS-1:0] pr_a1,
	output logic [PR_BITS-1:0] pr_a2,
	output logic [PR_BITS-1:0] pr_b1,
	output logic [PR_BITS-1:0] pr_b2,
	output logic pr_a1_ready,
	output logic pr_a2_ready,
	output logic pr_b1_ready,
	output logic pr_b2_ready,
	output logic [PR_BITS-1:0] told0,
	output logic [PR_BITS-1:0] told1
);

	logic [PR_BITS-1:0] spec_map [NUM_AR];	// speculative map
	logic [PR_BITS-1:0] ret_map [NUM_AR];	// retired map
	logic [NUM_AR-1:0] ready_bits;
	logic [NUM_AR-1:0] cdb_ready;	// with this cycle's completions
	logic [NUM_AR-1:0] next_ready;

	logic reads_a1, reads_a2, reads_b1, reads_b2;
	logic byp_b1, byp_b2;	// slot 1 source hits slot 0 dest

	assign reads_a1 = (opa_select0 == opa_is_rega);
	assign reads_a2 = (opb_select0 == opb_is_regb);
	assign reads_b1 = (opa_select1 == opa_is_rega);
	assign reads_b2 = (opb_select1 == opb_is_regb);

	assign byp_b1 = alloc0 && (ra_idx1 == dest_idx0);
	assign byp_b2 = alloc0 && (rb_idx1 == dest_idx0);

	// completion only counts while the tag is still the live mapping
	always_comb
	begin
		cdb_ready = ready_bits;
		for (int k = 0; k < CDB_WIDTH; k++)
		begin
			if (cdb_valid[k] && (spec_map[cdb_ar[k]] == cdb_pr[k]))
				cdb_ready[cdb_ar[k]] = 1'b1;
		end
		next_ready = cdb_ready;
		if (alloc0)
			next_ready[dest_idx0] = 1'b0;	// fresh tag not produced yet
		if (alloc1)
			next_ready[dest_idx1] = 1'b0;
	end

	// ************************************************************************
	// source lookup and old tags
	// ************************************************************************

	assign pr_a1 = spec_map[ra_idx0];
	assign pr_a2 = spec_map[rb_idx0];
	assign pr_b1 = byp_b1 ? fl_pr0 : spec_map[ra_idx1];
	assign pr_b2 = byp_b2 ? fl_pr0 : spec_map[rb_idx1];

	assign pr_a1_ready = cdb_ready[ra_idx0] | ~reads_a1;
	assign pr_a2_ready = cdb_ready[rb_idx0] | ~reads_a2;
	assign pr_b1_ready = (cdb_ready[ra_idx1] & ~byp_b1) | ~reads_b1;
	assign pr_b2_ready = (cdb_ready[rb_idx1] & ~byp_b2) | ~reads_b2;

	assign told0 = spec_map[dest_idx0];
	assign told1 = (alloc0 && (dest_idx1 == dest_idx0)) ? fl_pr0 : spec_map[dest_idx1];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_AR; i++)
			begin
				spec_map[i] <= PR_BITS'(i);	// identity map
				ret_map[i] <= PR_BITS'(i);
			end
			ready_bits <= '1;
		end
		else if (recover)
		begin
			spec_map <= ret_map;
			ready_bits <= '1;
		end
		else
		begin
			ready_bits <= next_ready;
			if (alloc0)
				spec_map[dest_idx0] <= fl_pr0;
			if (alloc1)
				spec_map[dest_idx1] <= fl_pr1;	// slot 1 wins on same dest
			if (ret_valid0)
				ret_map[ret_ar0] <= ret_pr0;
			if (ret_valid1)
				ret_map[ret_ar1] <= ret_pr1;
		end
	end

endmodule

//--- src/free_list.sv
`timescale 1ns/1ps

module free_list import rename_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic recover,
	input  logic alloc0,
	input  logic alloc1,
	input  logic ret_valid0,
	input  logic ret_valid1,
	input  logic [PR_BITS-1:0] ret_told0,
	input  logic [PR_BITS-1:0] ret_told1,
	output logic [PR_BITS-1:0] fl_pr0,
	output logic [PR_BITS-1:0] fl_pr1,
	output logic [FL_PTR_BITS:0] free_count
);

	localparam int FL_SLOTS = NUM_FREE + 1;	// one spare slot, full never equals empty

	logic [PR_BITS-1:0] tags [FL_SLOTS];
	logic [FL_PTR_BITS-1:0] head, tail, ret_head;
	logic [FL_PTR_BITS-1:0] head1, head2, tail1, ret_head1, ret_head2;

	function automatic logic [FL_PTR_BITS-1:0] fl_inc(input logic [FL_PTR_BITS-1:0] p);
		return (p == FL_PTR_BITS'(NUM_FREE)) ? '0 : p + 1'b1;
	endfunction

	assign head1 = fl_inc(head);
	assign head2 = fl_inc(head1);
	assign tail1 = fl_inc(tail);
	assign ret_head1 = fl_inc(ret_head);
	assign ret_head2 = fl_inc(ret_head1);

	// slot 1 takes the head tag when slot 0 is idle
	assign fl_pr0 = tags[head];
	assign fl_pr1 = alloc0 ? tags[head1] : tags[head];

	assign free_count = (tail >= head) ? {1'b0, tail} - {1'b0, head}
		: {1'b0, tail} + (FL_PTR_BITS+1)'(FL_SLOTS) - {1'b0, head};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_FREE; i++)
				tags[i] <= PR_BITS'(NUM_AR + i);	// tags above the identity map
			head <= '0;
			tail <= FL_PTR_BITS'(NUM_FREE);
			ret_head <= '0;
		end
		else if (recover)
			head <= ret_head;	// drop every speculative allocation
		else
		begin
			case ({alloc0, alloc1})
				2'b11: head <= head2;
				2'b10, 2'b01: head <= head1;
				default: head <= head;
			endcase

			// old tags of retired entries come back in order
			if (ret_valid0)
				tags[tail] <= ret_told0;
			if (ret_valid1)
				tags[ret_valid0 ? tail1 : tail] <= ret_told1;
			case ({ret_valid0, ret_valid1})
				2'b11: tail <= fl_inc(tail1);
				2'b10, 2'b01: tail <= tail1;
				default: tail <= tail;
			endcase

			case ({ret_valid0, ret_valid1})
				2'b11: ret_head <= ret_head2;
				2'b10, 2'b01: ret_head <= ret_head1;
				default: ret_head <= ret_head;
			endcase
		end
	end

endmodule

//--- src/retire_queue.sv
`timescale 1ns/1ps

module retire_queue import rename_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic recover,
	input  logic alloc0,
	input  logic alloc1,
	input  logic [AR_BITS-1:0] dest_idx0,
	input  logic [AR_BITS-1:0] dest_idx1,
	input  logic [PR_BITS-1:0] fl_pr0,
	input  logic [PR_BITS-1:0] fl_pr1,
	input  logic [PR_BITS-1:0] told0,
	input  logic [PR_BITS-1:0] told1,
	input  logic [1:0] retire_num,
	output logic ret_valid0,
	output logic ret_valid1,
	output logic [AR_BITS-1:0] ret_ar0,
	output logic [AR_BITS-1:0] ret_ar1,
	output logic [PR_BITS-1:0] ret_pr0,
	output logic [PR_BITS-1:0] ret_pr1,
	output logic [PR_BITS-1:0] ret_told0,
	output logic [PR_BITS-1:0] ret_told1,
	output logic [RQ_PTR_BITS:0] space
);

	logic [AR_BITS-1:0] q_ar [RQ_DEPTH];
	logic [PR_BITS-1:0] q_pr [RQ_DEPTH];
	logic [PR_BITS-1:0] q_told [RQ_DEPTH];
	logic [RQ_PTR_BITS-1:0] head, tail;	// pointers wrap on their own
	logic [RQ_PTR_BITS:0] count;
	logic [1:0] pop_n;
	logic [RQ_PTR_BITS-1:0] tail_b;	// slot for the second push

	// clamp to two and to what is actually held
	always_comb
	begin
		pop_n = (retire_num > 2'd2) ? 2'd2 : retire_num;
		if ({{(RQ_PTR_BITS-1){1'b0}}, pop_n} > count)
			pop_n = count[1:0];
	end

	assign ret_valid0 = (pop_n != 2'd0);
	assign ret_valid1 = (pop_n == 2'd2);
	assign ret_ar0 = q_ar[head];
	assign ret_ar1 = q_ar[head + 1'b1];
	assign ret_pr0 = q_pr[head];
	assign ret_pr1 = q_pr[head + 1'b1];
	assign ret_told0 = q_told[head];
	assign ret_told1 = q_told[head + 1'b1];

	assign space = (RQ_PTR_BITS+1)'(RQ_DEPTH) - count;
	assign tail_b = alloc0 ? tail + 1'b1 : tail;

	always_ff @(posedge clock)
	begin
		if (reset || recover)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (alloc0)
			begin
				q_ar[tail] <= dest_idx0;
				q_pr[tail] <= fl_pr0;
				q_told[tail] <= told0;
			end
			if (alloc1)
			begin
				q_ar[tail_b] <= dest_idx1;
				q_pr[tail_b] <= fl_pr1;
				q_told[tail_b] <= told1;
			end
			tail <= tail + RQ_PTR_BITS'(alloc0) + RQ_PTR_BITS'(alloc1);
			head <= head + RQ_PTR_BITS'(pop_n);
			count <= count + (RQ_PTR_BITS+1)'(alloc0) + (RQ_PTR_BITS+1)'(alloc1)
				- (RQ_PTR_BITS+1)'(pop_n);
		end
	end

endmodule

//--- src/rename_unit.sv
`timescale 1ns/1ps

module rename_unit import rename_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic [1:0] dispatch_num,
	input  logic valid0,
	input  logic valid1,
	input  opa_select_t opa_select0,
	input  opa_select_t opa_select1,
	input  opb_select_t opb_select0,
	input  opb_select_t opb_select1,
	input  logic [AR_BITS-1:0] ra_idx0,
	input  logic [AR_BITS-1:0] ra_idx1,
	input  logic [AR_BITS-1:0] rb_idx0,
	input  logic [AR_BITS-1:0] rb_idx1,
	input  logic [AR_BITS-1:0] dest_idx0,
	input  logic [AR_BITS-1:0] dest_idx1,
	input  logic [CDB_WIDTH-1:0] cdb_valid,
	input  logic [CDB_WIDTH-1:0][AR_BITS-1:0] cdb_ar,
	input  logic [CDB_WIDTH-1:0][PR_BITS-1:0] cdb_pr,
	input  logic [1:0] retire_num,
	input  logic recover,
	output logic [PR_BITS-1:0] pr_a1,
	output logic [PR_BITS-1:0] pr_a2,
	output logic [PR_BITS-1:0] pr_b1,
	output logic [PR_BITS-1:0] pr_b2,
	output logic [PR_BITS-1:0] told0,
	output logic [PR_BITS-1:0] told1,
	output logic [PR_BITS-1:0] new_pr0,
	output logic [PR_BITS-1:0] new_pr1,
	output logic pr_a1_ready,
	output logic pr_a2_ready,
	output logic pr_b1_ready,
	output logic pr_b2_ready,
	output logic dispatch_ready
);

	logic alloc0, alloc1;	// slots actually renamed this cycle
	logic [PR_BITS-1:0] fl_pr0, fl_pr1;
	logic [FL_PTR_BITS:0] free_count;
	logic [RQ_PTR_BITS:0] space;
	logic ret_valid0, ret_valid1;
	logic [AR_BITS-1:0] ret_ar0, ret_ar1;
	logic [PR_BITS-1:0] ret_pr0, ret_pr1, ret_told0, ret_told1;

	// room for a full pair in both the free list and the queue
	assign dispatch_ready = (free_count >= (FL_PTR_BITS+1)'(2))
		&& (space >= (RQ_PTR_BITS+1)'(2));
	assign alloc0 = dispatch_ready && valid0 && (dispatch_num != 2'd0);
	assign alloc1 = dispatch_ready && valid1 && (dispatch_num >= 2'd2);
	assign new_pr0 = fl_pr0;
	assign new_pr1 = fl_pr1;

	map_table u_map_table (.*);
	free_list u_free_list (.*);
	retire_queue u_retire_queue (.*);

endmodule

//--- tb/rename_assert.sv
`timescale 1ns/1ps

module rename_assert import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic recover,
	input logic alloc0,
	input logic alloc1,
	input logic [AR_BITS-1:0] ra_idx1,
	input logic [AR_BITS-1:0] rb_idx1,
	input logic [AR_BITS-1:0] dest_idx0,
	input logic pr_a1_ready,
	input logic pr_a2_ready,
	input logic pr_b1_ready,
	input logic pr_b2_ready,
	input logic [PR_BITS-1:0] new_pr0,
	input logic [PR_BITS-1:0] new_pr1,
	input logic dispatch_ready
);

	ready_after_reset: assert property (@(posedge clock)
		$past(reset) && !reset |-> dispatch_ready)
		else $error("dispatch_ready low right after reset");

	// every register is ready again once the map is restored
	ready_after_recover: assert property (@(posedge clock) disable iff (reset)
		recover |=> pr_a1_ready && pr_a2_ready
			&& (pr_b1_ready || (alloc0 && ra_idx1 == dest_idx0))	// fed by slot 0
			&& (pr_b2_ready || (alloc0 && rb_idx1 == dest_idx0)))
		else $error("source not ready one cycle after recover");

	distinct_new_tags: assert property (@(posedge clock) disable iff (reset)
		alloc0 && alloc1 |-> new_pr0 != new_pr1)
		else $error("both slots got the same new tag");

endmodule

bind rename_unit rename_assert u_rename_assert (.*);

//--- tb/rename_tb.sv
`timescale 1ns/1ps

module rename_tb import rename_pkg::*;;

	typedef struct {
		int dnum, opa0, opa1, opb0, opb1, ra0, rb0, d0, ra1, rb1, d1;
		bit [1:0] cv;
		int car0, cpr0, car1, cpr1, retn;
		bit rec;
	} row_t;

	logic clock, reset, valid0, valid1, recover;
	logic [1:0] dispatch_num, retire_num;
	opa_select_t opa_select0, opa_select1;
	opb_select_t opb_select0, opb_select1;
	logic [AR_BITS-1:0] ra_idx0, ra_idx1, rb_idx0, rb_idx1, dest_idx0, dest_idx1;
	logic [CDB_WIDTH-1:0] cdb_valid;
	logic [CDB_WIDTH-1:0][AR_BITS-1:0] cdb_ar;
	logic [CDB_WIDTH-1:0][PR_BITS-1:0] cdb_pr;
	logic [PR_BITS-1:0] pr_a1, pr_a2, pr_b1, pr_b2, told0, told1, new_pr0, new_pr1;
	logic pr_a1_ready, pr_a2_ready, pr_b1_ready, pr_b2_ready, dispatch_ready;

	row_t tbl[$];
	int spec[NUM_AR], rmap[NUM_AR];	// shadow maps
	bit rdy[NUM_AR];
	int fl_q[$], fl_head, fl_ret_head;	// every tag ever queued in order
	int rq_ar[$], rq_pr[$], rq_told[$];

	rename_unit UUT (.*);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input int dnum, ra0, rb0, d0, ra1, rb1, d1);
		row_t r;
		r = '{dnum: dnum, ra0: ra0, rb0: rb0, d0: d0, ra1: ra1, rb1: rb1, d1: d1, default: 0};
		tbl.push_back(r);
	endtask

	task automatic drive_idle();
		{valid0, valid1, recover, dispatch_num, retire_num, cdb_valid} = '0;
	endtask

	task automatic apply_row(input row_t r);
		bit a0, a1, byp1, byp2, dr;
		bit cr[NUM_AR];
		int np0, np1, t0, t1, n, cnt;
		@(negedge clock);
		drive_idle();
		cnt = 0;
		while (r.dnum != 0 && !dispatch_ready)
		begin
			if (cnt >= 50)
			begin
				$display("timeout while waiting for dispatch_ready");
				$display("tests failed");
				$fatal(1, "timeout");
			end
			cnt++;
			@(negedge clock);
		end
		dispatch_num = 2'(r.dnum);
		{valid0, valid1} = 2'b11;
		opa_select0 = opa_select_t'(r.opa0[1:0]);
		opa_select1 = opa_select_t'(r.opa1[1:0]);
		opb_select0 = opb_select_t'(r.opb0[1:0]);
		opb_select1 = opb_select_t'(r.opb1[1:0]);
		{ra_idx0, rb_idx0, dest_idx0} = {AR_BITS'(r.ra0), AR_BITS'(r.rb0), AR_BITS'(r.d0)};
		{ra_idx1, rb_idx1, dest_idx1} = {AR_BITS'(r.ra1), AR_BITS'(r.rb1), AR_BITS'(r.d1)};
		cdb_valid = r.cv;
		cdb_ar[0] = AR_BITS'(r.car0);
		cdb_ar[1] = AR_BITS'(r.car1);
		cdb_pr[0] = PR_BITS'(r.cpr0);
		cdb_pr[1] = PR_BITS'(r.cpr1);
		retire_num = 2'(r.retn);
		recover = r.rec;
		#1;

		// ****************************************************************************
		// expected values from the shadow state
		// ****************************************************************************
		dr = (fl_q.size() - fl_head >= 2) && (RQ_DEPTH - rq_ar.size() >= 2);
		a0 = dr && r.dnum != 0;
		a1 = dr && r.dnum >= 2;
		cr = rdy;
		if (r.cv[0] && spec[r.car0] == r.cpr0)
			cr[r.car0] = 1'b1;
		if (r.cv[1] && spec[r.car1] == r.cpr1)
			cr[r.car1] = 1'b1;
		np0 = fl_q[fl_head];
		np1 = a0 ? fl_q[fl_head + 1] : np0;
		byp1 = a0 && r.ra1 == r.d0;
		byp2 = a0 && r.rb1 == r.d0;
		t0 = spec[r.d0];
		t1 = (a0 && r.d1 == r.d0) ? np0 : spec[r.d1];
		check("dispatch_ready", dispatch_ready, dr);
		check("pr_a1", pr_a1, spec[r.ra0]);
		check("pr_a2", pr_a2, spec[r.rb0]);
		check("pr_b1", pr_b1, byp1 ? np0 : spec[r.ra1]);
		check("pr_b2", pr_b2, byp2 ? np0 : spec[r.rb1]);
		check("pr_a1_ready", pr_a1_ready, r.opa0 != 0 || cr[r.ra0]);
		check("pr_a2_ready", pr_a2_ready, r.opb0 != 0 || cr[r.rb0]);
		check("pr_b1_ready", pr_b1_ready, r.opa1 != 0 || (!byp1 && cr[r.ra1]));
		check("pr_b2_ready", pr_b2_ready, r.opb1 != 0 || (!byp2 && cr[r.rb1]));
		if (a0)
		begin
			check("told0", told0, t0);
			check("new_pr0", new_pr0, np0);
		end
		if (a1)
		begin
			check("told1", told1, t1);
			check("new_pr1", new_pr1, np1);
		end
		@(posedge clock);

		if (r.rec)
		begin
			spec = rmap;
			rdy = '{default: 1'b1};
			fl_head = fl_ret_head;
			rq_ar.delete();
			rq_pr.delete();
			rq_told.delete();
		end
		else
		begin
			n = (r.retn > 2) ? 2 : r.retn;
			n = (n > rq_ar.size()) ? rq_ar.size() : n;	// clamp to occupancy
			repeat (n)
			begin
				rmap[rq_ar[0]] = rq_pr[0];
				fl_q.push_back(rq_told.pop_front());
				void'(rq_ar.pop_front());
				void'(rq_pr.pop_front());
				fl_ret_head++;
			end
			rdy = cr;
			if (a0)
			begin
				rdy[r.d0] = 1'b0;
				spec[r.d0] = np0;
				rq_ar.push_back(r.d0);
				rq_pr.push_back(np0);
				rq_told.push_back(t0);
				fl_head++;
			end
			if (a1)
			begin
				rdy[r.d1] = 1'b0;
				spec[r.d1] = np1;	// slot 1 wins on same dest
				rq_ar.push_back(r.d1);
				rq_pr.push_back(np1);
				rq_told.push_back(t1);
				fl_head++;
			end
		end
	endtask

	initial
	begin
		void'($urandom(32'h3c28));
		drive_idle();
		{opa_select0, opa_select1} = {opa_is_rega, opa_is_rega};
		{opb_select0, opb_select1} = {opb_is_regb, opb_is_regb};
		{ra_idx0, ra_idx1, rb_idx0, rb_idx1, dest_idx0, dest_idx1} = '0;
		cdb_ar = '0;
		cdb_pr = '0;
		for (int i = 0; i < NUM_AR; i++)
		begin
			spec[i] = i;	// identity after reset
			rmap[i] = i;
			rdy[i] = 1'b1;
		end
		for (int i = 0; i < NUM_FREE; i++)
			fl_q.push_back(NUM_AR + i);
		reset = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		add_row(2, 1, 2, 3, 4, 5, 6);	// plain pair takes tags 32 and 33
		add_row(2, 3, 6, 7, 7, 2, 7);	// bypass and same dest
		add_row(0, 7, 3, 0, 6, 3, 0);	// completion with a stale lane 1
		tbl[2].cv = 2'b11;
		{tbl[2].car0, tbl[2].cpr0, tbl[2].car1, tbl[2].cpr1} = {32'd7, 32'd35, 32'd6, 32'd34};
		add_row(1, 1, 1, 3, 0, 0, 0);	// re-rename r3
		add_row(0, 3, 1, 0, 1, 1, 0);
		tbl[4].cv = 2'b01;
		{tbl[4].car0, tbl[4].cpr0} = {32'd3, 32'd32};	// old tag of r3
		add_row(0, 6, 7, 0, 3, 6, 0);	// non-register operands
		{tbl[5].opa0, tbl[5].opb0, tbl[5].opa1, tbl[5].opb1} = {32'd2, 32'd3, 32'd1, 32'd1};
		add_row(0, 0, 0, 0, 0, 0, 0);
		tbl[6].retn = 2;
		add_row(2, 1, 2, 8, 3, 4, 9);
		tbl[7].retn = 1;
		add_row(2, 3, 7, 3, 8, 9, 10);
		add_row(2, 1, 2, 13, 4, 5, 14);	// recover beats dispatch
		tbl[9].rec = 1'b1;
		add_row(2, 3, 7, 11, 8, 6, 12);
		add_row(0, 0, 0, 0, 0, 0, 0);
		tbl[11].retn = 3;
		add_row(0, 0, 0, 0, 0, 0, 0);	// empty queue
		tbl[12].retn = 3;
		repeat (60)
		begin
			add_row(2, $urandom % NUM_AR, $urandom % NUM_AR, $urandom % NUM_AR,
				$urandom % NUM_AR, $urandom % NUM_AR, $urandom % NUM_AR);
			tbl[tbl.size() - 1].retn = 2;	// keeps freed tags cycling back
		end

		foreach (tbl[i])
			apply_row(tbl[i]);
		$display("all tests passed");
		$finish;
	end

endmodule

//--- src.f
src/rename_pkg.sv
src/map_table.sv
src/free_list.sv
src/retire_queue.sv
src/rename_unit.sv
tb/rename_assert.sv
tb/rename_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, then run it and look for the pass message
verilator --binary --timing --assert -f src.f --top-module rename_tb -o rename_sim \
	&& ./obj_dir/rename_sim | tee /dev/stderr | grep -q "all tests passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
